/* Bender.yml */
package:
  name: soc

sources:
  - include_dirs:
      - design
    files:
      - design/soc_pkg.sv
      - design/bus_arbiter.sv
      - design/ram.sv
      - design/sync_fifo.sv
      - design/uart_tx.sv
      - design/uart_rx.sv
      - design/uart.sv
      - design/soc_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/soc_asserts.sv
      - sim/soc_tb.sv

/* design/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter (
    input  logic              pll_clk,
    input  logic              rst,

    input  soc_pkg::mem_req_t instr_req,
    output logic              instr_ready,
    output logic [31:0]       instr_read_value,

    input  soc_pkg::mem_req_t data_req,
    output logic              data_ready,
    output logic [31:0]       data_read_value,

    output soc_pkg::mem_req_t mem_req,
    input  logic [31:0]       read_value
);
    import soc_pkg::*;

    logic     resp;
    logic     grant_data;
    logic     data_active;
    logic     instr_active;
    mem_req_t chosen;

    assign data_active  = data_req.read || data_req.write;
    assign instr_active = instr_req.read;

    always_comb begin
        chosen = data_active ? data_req : instr_req;
        // The instruction port never writes.
        if (!data_active) begin
            chosen.write = 1'b0;
        end
        mem_req = (!resp && (data_active || instr_active)) ? chosen : '0;
    end

    // The bus alternates between an access cycle and a response cycle.
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            resp       <= 1'b0;
            grant_data <= 1'b0;
        end else if (resp) begin
            resp <= 1'b0;
        end else if (data_active || instr_active) begin
            resp       <= 1'b1;
            grant_data <= data_active;
        end
    end

    assign data_ready  = resp && grant_data;
    assign instr_ready = resp && !grant_data;

    assign data_read_value  = data_ready ? read_value : '0;
    assign instr_read_value = instr_ready ? read_value : '0;
endmodule

/* design/ram.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module ram (
    input  logic              pll_clk,
    input  soc_pkg::mem_req_t req,
    input  logic              sel,
    output logic [31:0]       read_value
);
    localparam int addr_w = $clog2(`SOC_RAM_WORDS);

    logic [31:0]       mem [`SOC_RAM_WORDS];
    logic [addr_w-1:0] word;

    // Byte address to word index, wrapping at the RAM size.
    assign word = req.addr[addr_w+1:2];

    always_ff @(posedge pll_clk) begin
        if (sel && req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (req.mask[i]) begin
                    mem[word][i*8 +: 8] <= req.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Zero when not selected so the bus can OR all targets.
    always_ff @(posedge pll_clk) begin
        read_value <= (sel && req.read) ? mem[word] : '0;
    end
endmodule

/* design/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Number of 32-bit words in the RAM.
`define SOC_RAM_WORDS 256

// Upper 16 address bits of each peripheral region.
// The RAM owns every address whose upper half is zero.
`define SOC_LEDS_BASE 16'h0001
`define SOC_UART_BASE 16'h0002

// Number of pll_clk cycles in one UART bit.
`define SOC_UART_DIV 8

// Number of entries in each UART FIFO.
`define SOC_FIFO_DEPTH 4

`endif

/* design/soc_pkg.sv */
package soc_pkg;

    // One access on a master port or on the common bus.
    // A request with neither read nor write set is idle.
    typedef struct packed {
        logic [31:0] addr;
        logic        read;
        logic        write;
        logic [3:0]  mask;
        logic [31:0] wdata;
    } mem_req_t;

    // One character from the UART receiver.
    typedef struct packed {
        logic [7:0] data;
        logic       frame_err;
    } rx_entry_t;

endpackage

/* design/soc_top.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_top (
    input  logic              pll_clk,
    input  logic              rst,

    input  soc_pkg::mem_req_t instr_req,
    output logic              instr_ready,
    output logic [31:0]       instr_read_value,

    input  soc_pkg::mem_req_t data_req,
    output logic              data_ready,
    output logic [31:0]       data_read_value,

    output logic [7:0]        leds,

    input  logic              uart_rx,
    output logic              uart_tx
);
    import soc_pkg::*;

    mem_req_t    mem_req;
    logic [31:0] mem_read_value;
    logic        ram_sel;
    logic        leds_sel;
    logic        uart_sel;
    logic [31:0] ram_read_value;
    logic [31:0] leds_read_value;
    logic [31:0] uart_read_value;

    bus_arbiter u_bus_arbiter (
        .pll_clk(pll_clk),
        .rst(rst),
        .instr_req(instr_req),
        .instr_ready(instr_ready),
        .instr_read_value(instr_read_value),
        .data_req(data_req),
        .data_ready(data_ready),
        .data_read_value(data_read_value),
        .mem_req(mem_req),
        .read_value(mem_read_value)
    );

    always_comb begin
        ram_sel  = 1'b0;
        leds_sel = 1'b0;
        uart_sel = 1'b0;
        casez (mem_req.addr[31:16])
            16'h0000:       ram_sel = 1'b1;
            `SOC_LEDS_BASE: leds_sel = mem_req.addr[15:2] == '0;
            `SOC_UART_BASE: uart_sel = mem_req.addr[15:4] == '0;
            default:        ;
        endcase
    end

    ram u_ram (
        .pll_clk(pll_clk),
        .req(mem_req),
        .sel(ram_sel),
        .read_value(ram_read_value)
    );

    always_ff @(posedge pll_clk) begin
        if (rst) begin
            leds <= '0;
        end else if (leds_sel && mem_req.write && mem_req.mask[0]) begin
            leds <= mem_req.wdata[7:0];
        end
    end

    always_ff @(posedge pll_clk) begin
        leds_read_value <= (leds_sel && mem_req.read) ? {24'b0, leds} : '0;
    end

    uart u_uart (
        .pll_clk(pll_clk),
        .rst(rst),
        .req(mem_req),
        .sel(uart_sel),
        .read_value(uart_read_value),
        .rx(uart_rx),
        .tx(uart_tx)
    );

    // Unselected targets return zero, so their values simply combine.
    assign mem_read_value = ram_read_value | leds_read_value | uart_read_value;
endmodule

/* design/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     pll_clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);
    localparam int ptr_w = $clog2(depth);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full  = count == (ptr_w + 1)'(depth);
    assign empty = count == '0;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // The head entry is visible before it is popped.
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge pll_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge pll_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end
endmodule

/* design/uart.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module uart (
    input  logic              pll_clk,
    input  logic              rst,
    input  soc_pkg::mem_req_t req,
    input  logic              sel,
    output logic [31:0]       read_value,
    input  logic              rx,
    output logic              tx
);
    import soc_pkg::*;

    logic       data_sel;
    logic       status_sel;
    logic       tx_push;
    logic       tx_pop;
    logic [7:0] tx_head;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_busy;
    logic       rx_push;
    logic       rx_pop;
    logic       rx_empty;
    rx_entry_t  rx_entry;
    rx_entry_t  rx_head;

    // DATA sits at offset 0 and STATUS at offset 4.
    assign data_sel   = sel && req.addr[3:2] == 2'd0;
    assign status_sel = sel && req.addr[3:2] == 2'd1;

    assign tx_push = data_sel && req.write && req.mask[0];
    assign rx_pop  = data_sel && req.read;

    sync_fifo #(
        .payload_t(logic [7:0]),
        .depth(`SOC_FIFO_DEPTH)
    ) u_tx_fifo (
        .pll_clk(pll_clk),
        .rst(rst),
        .push(tx_push),
        .push_data(req.wdata[7:0]),
        .pop(tx_pop),
        .pop_data(tx_head),
        .full(tx_full),
        .empty(tx_empty)
    );

    uart_tx u_uart_tx (
        .pll_clk(pll_clk),
        .rst(rst),
        .data(tx_head),
        .empty(tx_empty),
        .pop(tx_pop),
        .busy(tx_busy),
        .tx(tx)
    );

    uart_rx u_uart_rx (
        .pll_clk(pll_clk),
        .rst(rst),
        .rx(rx),
        .push(rx_push),
        .entry(rx_entry)
    );

    // A full receive FIFO drops the new character.
    sync_fifo #(
        .payload_t(rx_entry_t),
        .depth(`SOC_FIFO_DEPTH)
    ) u_rx_fifo (
        .pll_clk(pll_clk),
        .rst(rst),
        .push(rx_push),
        .push_data(rx_entry),
        .pop(rx_pop),
        .pop_data(rx_head),
        .full(),
        .empty(rx_empty)
    );

    always_ff @(posedge pll_clk) begin
        if (rx_pop && !rx_empty) begin
            read_value <= {23'b0, rx_head.frame_err, rx_head.data};
        end else if (status_sel && req.read) begin
            read_value <= {29'b0, tx_busy, !rx_empty, tx_full};
        end else begin
            read_value <= '0;
        end
    end
endmodule

/* design/uart_rx.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module uart_rx (
    input  logic                pll_clk,
    input  logic                rst,
    input  logic                rx,
    output logic                push,
    output soc_pkg::rx_entry_t  entry
);
    localparam int div_w = $clog2(`SOC_UART_DIV);

    logic [2:0]       rx_q;
    logic             rx_s;
    logic             start_edge;
    logic             busy;
    logic [3:0]       bit_idx;
    logic [div_w-1:0] div_cnt;
    logic             sample;
    logic [7:0]       shift;

    // Two synchronizer flops, and a third to find the falling edge.
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            rx_q <= '1;
        end else begin
            rx_q <= {rx_q[1:0], rx};
        end
    end

    assign rx_s       = rx_q[1];
    assign start_edge = rx_q[2] && !rx_q[1];
    assign sample     = busy && div_cnt == div_w'(`SOC_UART_DIV - 1);

    // Bit 0 is the start bit, bits 1 to 8 are data, bit 9 is the stop bit.
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            busy    <= 1'b0;
            push    <= 1'b0;
            bit_idx <= '0;
            div_cnt <= '0;
        end else begin
            push <= 1'b0;
            if (!busy) begin
                if (start_edge) begin
                    // Half a bit of preload puts every sample mid-bit.
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    div_cnt <= div_w'(`SOC_UART_DIV / 2);
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
                if (sample) begin
                    div_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 4'd0 && rx_s) begin
                        busy <= 1'b0;
                    end else if (bit_idx == 4'd9) begin
                        busy <= 1'b0;
                        push <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (sample) begin
            if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
                shift <= {rx_s, shift[7:1]};
            end
            if (bit_idx == 4'd9) begin
                entry.data      <= shift;
                entry.frame_err <= !rx_s;
            end
        end
    end
endmodule

/* design/uart_tx.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module uart_tx (
    input  logic       pll_clk,
    input  logic       rst,
    input  logic [7:0] data,
    input  logic       empty,
    output logic       pop,
    output logic       busy,
    output logic       tx
);
    localparam int div_w = $clog2(`SOC_UART_DIV);

    logic [9:0]       frame;
    logic [3:0]       bit_cnt;
    logic [div_w-1:0] div_cnt;
    logic             bit_end;

    assign pop     = !busy && !empty;
    assign bit_end = div_cnt == div_w'(`SOC_UART_DIV - 1);

    // The frame shifts in ones, so the line idles high.
    assign tx = frame[0];

    always_ff @(posedge pll_clk) begin
        if (rst) begin
            frame   <= '1;
            busy    <= 1'b0;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (pop) begin
            // Stop bit, data LSB first, then the start bit.
            frame   <= {1'b1, data, 1'b0};
            busy    <= 1'b1;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (busy) begin
            div_cnt <= div_cnt + 1'b1;
            if (bit_end) begin
                div_cnt <= '0;
                frame   <= {1'b1, frame[9:1]};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end
            end
        end
    end
endmodule

/* sim.f */
+incdir+design
design/soc_pkg.sv
design/bus_arbiter.sv
design/ram.sv
design/sync_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart.sv
design/soc_top.sv
sim/soc_asserts.sv
sim/soc_tb.sv

/* sim/soc_asserts.sv */
`timescale 1ns/100ps

module soc_asserts (
    input logic              pll_clk,
    input logic              rst,
    input soc_pkg::mem_req_t mem_req,
    input logic              instr_ready,
    input logic              data_ready,
    input logic              uart_tx
);
    logic access;
    logic ready;
    int   fail_count = 0;

    assign access = mem_req.read || mem_req.write;
    assign ready  = instr_ready || data_ready;

    // An access on the common bus is answered in the very next cycle, and only then.
    property ready_after_access;
        @(posedge pll_clk) disable iff (rst) access |=> ready;
    endproperty

    property ready_needs_access;
        @(posedge pll_clk) disable iff (rst) ready |-> $past(access);
    endproperty

    property one_ready_at_a_time;
        @(posedge pll_clk) disable iff (rst) !(instr_ready && data_ready);
    endproperty

    // The response cycle leaves the bus idle.
    property idle_in_response;
        @(posedge pll_clk) disable iff (rst) ready |-> !access;
    endproperty

    property tx_idle_after_reset;
        @(posedge pll_clk) $fell(rst) |-> uart_tx;
    endproperty

    a_ready_after_access: assert property (ready_after_access)
        else begin
            fail_count++;
            $error("no ready strobe in the cycle after a bus access");
        end

    a_ready_needs_access: assert property (ready_needs_access)
        else begin
            fail_count++;
            $error("ready strobe without a bus access in the cycle before");
        end

    a_one_ready_at_a_time: assert property (one_ready_at_a_time)
        else begin
            fail_count++;
            $error("instruction and data ready are high together");
        end

    a_idle_in_response: assert property (idle_in_response)
        else begin
            fail_count++;
            $error("common bus is busy during a response cycle");
        end

    a_tx_idle_after_reset: assert property (tx_idle_after_reset)
        else begin
            fail_count++;
            $error("uart_tx is not high after reset");
        end
endmodule

bind soc_top soc_asserts u_soc_asserts (
    .pll_clk(pll_clk),
    .rst(rst),
    .mem_req(mem_req),
    .instr_ready(instr_ready),
    .data_ready(data_ready),
    .uart_tx(uart_tx)
);

/* sim/soc_tb.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_tb;
    import soc_pkg::*;

    localparam logic [31:0] leds_addr   = {`SOC_LEDS_BASE, 16'h0000};
    localparam logic [31:0] uart_data   = {`SOC_UART_BASE, 16'h0000};
    localparam logic [31:0] uart_status = {`SOC_UART_BASE, 16'h0004};
    localparam int          test_words  = 16;
    localparam int          max_cycles  = 20000;

    logic        pll_clk;
    logic        rst;
    mem_req_t    instr_req;
    logic        instr_ready;
    logic [31:0] instr_read_value;
    mem_req_t    data_req;
    logic        data_ready;
    logic [31:0] data_read_value;
    logic [7:0]  leds;
    logic        uart_tx;
    logic        uart_loop;
    logic        stop_fault;
    logic [31:0] rng;
    logic [31:0] shadow [test_words];
    int          cycles;

    // The line idles high until the DUT drives it, and a fault pulls it low.
    assign uart_loop = (uart_tx !== 1'b0) && !stop_fault;

    soc_top u_soc_top (
        .pll_clk(pll_clk),
        .rst(rst),
        .instr_req(instr_req),
        .instr_ready(instr_ready),
        .instr_read_value(instr_read_value),
        .data_req(data_req),
        .data_ready(data_ready),
        .data_read_value(data_read_value),
        .leds(leds),
        .uart_rx(uart_loop),
        .uart_tx(uart_tx)
    );

    always #2 pll_clk = ~pll_clk;

    always @(negedge pll_clk) begin
        cycles = cycles + 1;
        if (u_soc_top.u_soc_asserts.fail_count != 0) begin
            $display("A bus or UART timing assertion failed at cycle %0d", cycles);
            $display("SIMULATION FAILED");
            $fatal(1);
        end else if (cycles >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Bytes with their mask bit set come from the new word.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic expect_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected)
            else begin
                $display("MISMATCH %s: expected 0x%08h, got 0x%08h", name, expected, actual);
                $display("SIMULATION FAILED");
                $fatal(1);
            end
    endtask

    // Called on a falling edge; returns on the falling edge where ready is seen.
    task automatic data_access(input logic [31:0] addr, input logic write,
                               input logic [3:0] mask, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        data_req.addr  = addr;
        data_req.read  = !write;
        data_req.write = write;
        data_req.mask  = mask;
        data_req.wdata = wdata;
        do @(negedge pll_clk); while (!data_ready);
        rdata    = data_read_value;
        data_req = '0;
    endtask

    task automatic instr_fetch(input logic [31:0] addr, output logic [31:0] rdata);
        instr_req.addr = addr;
        instr_req.read = 1'b1;
        do @(negedge pll_clk); while (!instr_ready);
        rdata     = instr_read_value;
        instr_req = '0;
    endtask

    task automatic receive_byte(output logic [31:0] value);
        logic [31:0] status;
        status = '0;
        while (!status[1]) begin
            data_access(uart_status, 1'b0, 4'h0, '0, status);
        end
        data_access(uart_data, 1'b0, 4'h0, '0, value);
    endtask

    // Holds the loopback low for the whole stop bit of the next character.
    task automatic corrupt_stop_bit();
        while (uart_tx) begin
            @(negedge pll_clk);
        end
        repeat (9 * `SOC_UART_DIV) @(negedge pll_clk);
        stop_fault = 1'b1;
        repeat (`SOC_UART_DIV) @(negedge pll_clk);
        stop_fault = 1'b0;
    endtask

    initial begin
        logic [31:0] value;
        logic [31:0] data;
        logic [7:0]  led_value;
        logic [7:0]  sent [$];
        int          word;
        int          gap;
        pll_clk    = 1'b0;
        rst        = 1'b1;
        instr_req  = '0;
        data_req   = '0;
        stop_fault = 1'b0;
        rng        = 32'd28152;
        cycles     = 0;
        repeat (16) @(negedge pll_clk);
        rst = 1'b0;

        // RAM: fill the test words, then merge random masked writes.
        for (int i = 0; i < test_words; i++) begin
            rng       = xorshift32(rng);
            shadow[i] = rng;
            data_access(i * 4, 1'b1, 4'hf, rng, value);
        end
        for (int i = 0; i < 2 * test_words; i++) begin
            rng  = xorshift32(rng);
            word = rng[3:0];
            data = xorshift32(rng);
            data_access(word * 4, 1'b1, rng[7:4], data, value);
            shadow[word] = merge_bytes(shadow[word], data, rng[7:4]);
            rng = data;
        end
        for (int i = 0; i < test_words; i++) begin
            data_access(i * 4, 1'b0, 4'h0, '0, value);
            expect_value("data_read_value", shadow[i], value);
            instr_fetch(i * 4, value);
            expect_value("instr_read_value", shadow[i], value);
        end
        // The word index wraps at the RAM size.
        instr_fetch((`SOC_RAM_WORDS + 3) * 4, value);
        expect_value("instr_read_value", shadow[3], value);

        // Both ports request in the same cycle.
        data_req.addr  = 32'd4;
        data_req.read  = 1'b1;
        instr_req.addr = 32'd8;
        instr_req.read = 1'b1;
        // The data port wins, so the instruction port sees no ready yet.
        do begin
            @(negedge pll_clk);
            expect_value("instr_ready", 32'd0, {31'h0, instr_ready});
        end while (!data_ready);
        expect_value("data_read_value", shadow[1], data_read_value);
        data_req = '0;
        gap      = 0;
        do begin
            @(negedge pll_clk);
            gap++;
        end while (!instr_ready);
        expect_value("instr_ready delay", 32'd2, gap);
        expect_value("instr_read_value", shadow[2], instr_read_value);
        instr_req = '0;

        // LED register.
        for (int i = 0; i < 4; i++) begin
            rng       = xorshift32(rng);
            led_value = rng[7:0];
            data_access(leds_addr, 1'b1, 4'b0001, rng, value);
            expect_value("leds", {24'h0, led_value}, {24'h0, leds});
            rng = xorshift32(rng);
            data_access(leds_addr, 1'b1, 4'b1110, rng, value);
            expect_value("leds", {24'h0, led_value}, {24'h0, leds});
            data_access(leds_addr, 1'b0, 4'h0, '0, value);
            expect_value("data_read_value", {24'h0, led_value}, value);
        end

        // UART loopback of three bytes.
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            sent.push_back(rng[7:0]);
            data_access(uart_data, 1'b1, 4'b0001, rng, value);
        end
        for (int i = 0; i < 3; i++) begin
            receive_byte(value);
            expect_value("uart rx data", {24'h0, sent.pop_front()}, value);
        end

        // A low stop bit sets the frame error.
        rng = xorshift32(rng);
        data_access(uart_data, 1'b1, 4'b0001, rng, value);
        corrupt_stop_bit();
        receive_byte(value);
        expect_value("uart rx data", {23'h0, 1'b1, rng[7:0]}, value);

        // The first byte keeps the serializer busy while the next five overflow the FIFO.
        for (int i = 0; i < 6; i++) begin
            rng = xorshift32(rng);
            sent.push_back(rng[7:0]);
            data_access(uart_data, 1'b1, 4'b0001, rng, value);
        end
        data_access(uart_status, 1'b0, 4'h0, '0, value);
        expect_value("uart status", 32'h5, value);
        void'(sent.pop_back());
        while (sent.size() > 0) begin
            receive_byte(value);
            expect_value("uart rx data", {24'h0, sent.pop_front()}, value);
        end
        value = 32'h1;
        while (value[0] || value[2]) begin
            data_access(uart_status, 1'b0, 4'h0, '0, value);
        end
        repeat (20 * `SOC_UART_DIV) @(negedge pll_clk);
        data_access(uart_status, 1'b0, 4'h0, '0, value);
        expect_value("uart status", 32'h0, value);

        if (u_soc_top.u_soc_asserts.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("Bus or UART timing assertions failed during the run");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end
endmodule
